/* filelist.f */
hdl/hpa_pkg.sv
hdl/dac_if.sv
hdl/csr_spi.sv
hdl/vol_mixer.sv
hdl/dac_drv.sv
hdl/hpa_core.sv
tests/hpa_tb.sv

/* hdl/csr_spi.sv */
module csr_spi
    import hpa_pkg::*;
(
    input  logic      clk245760,
    input  logic      rst,

    input  logic      spi_sck_i,
    input  logic      spi_ss_i,
    input  logic      spi_mosi_i,
    output logic      spi_miso_o,

    output vol_t      vol_l_o,
    output vol_t      vol_r_o,
    output logic      mute_o,
    output logic      underrun_clr_o,
    input  csr_data_t underrun_cnt_i
);

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA} state_t;

    state_t    state_q;
    logic [2:0] sck_ff;
    logic [2:0] ss_ff;
    logic [1:0] mosi_ff;
    logic       sck_rise;
    logic       sck_fall;
    logic       ss_fall;
    logic       ss_high;
    logic [3:0] bit_cnt_q;
    csr_data_t  sh_q;
    csr_data_t  sh_next;
    csr_addr_t  rd_addr;
    csr_data_t  rd_value;
    csr_data_t  rd_sh_q;
    csr_addr_t  addr_q;
    logic       wr_q;
    logic       addr_done;
    logic       data_done;
    vol_t       vol_l_q;
    vol_t       vol_r_q;
    logic       mute_q;
    logic       clr_q;
    logic       miso_q;

    // two-flop synchronisers, third flop for edges
    always_ff @(posedge clk245760) begin
        if (rst) begin
            sck_ff <= 3'b000;
            ss_ff  <= 3'b111;
        end else begin
            sck_ff <= {sck_ff[1:0], spi_sck_i};
            ss_ff  <= {ss_ff[1:0], spi_ss_i};
        end
    end

    always_ff @(posedge clk245760) begin
        mosi_ff <= {mosi_ff[0], spi_mosi_i};
    end

    assign sck_rise = sck_ff[1] & ~sck_ff[2];
    assign sck_fall = ~sck_ff[1] & sck_ff[2];
    assign ss_fall  = ~ss_ff[1] & ss_ff[2];
    assign ss_high  = ss_ff[1];

    // one shift register for the whole 24-bit frame
    assign sh_next = {sh_q[14:0], mosi_ff[1]};
    assign rd_addr = sh_next[6:0];

    assign addr_done = !ss_high && state_q == S_ADDR && sck_rise && bit_cnt_q == 4'd7;
    assign data_done = !ss_high && state_q == S_DATA && sck_rise && bit_cnt_q == 4'd15;

    always_comb begin
        case (rd_addr)
            CSR_VOL_L:    rd_value = vol_l_q;
            CSR_VOL_R:    rd_value = vol_r_q;
            CSR_CTRL:     rd_value = {15'd0, mute_q};
            CSR_UNDERRUN: rd_value = underrun_cnt_i;
            default:      rd_value = '0;
        endcase
    end

    always_ff @(posedge clk245760) begin
        if (sck_rise) begin
            sh_q <= sh_next;
        end
        if (addr_done) begin
            addr_q  <= rd_addr;
            wr_q    <= sh_next[7];
            rd_sh_q <= rd_value;
        end else if (state_q == S_DATA && sck_fall) begin
            rd_sh_q <= {rd_sh_q[14:0], 1'b0};
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            state_q   <= S_IDLE;
            bit_cnt_q <= '0;
            miso_q    <= 1'b0;
        end else if (ss_high) begin
            state_q <= S_IDLE;
            miso_q  <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (ss_fall) begin
                        state_q   <= S_ADDR;
                        bit_cnt_q <= '0;
                    end
                end
                S_ADDR: begin
                    if (addr_done) begin
                        state_q   <= S_DATA;
                        bit_cnt_q <= '0;
                    end else if (sck_rise) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
                S_DATA: begin
                    if (data_done) begin
                        state_q <= S_IDLE;
                    end else if (sck_rise) begin
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                    // miso changes on falling sck
                    if (sck_fall) begin
                        miso_q <= rd_sh_q[15];
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // register writes, unknown addresses dropped
    always_ff @(posedge clk245760) begin
        if (rst) begin
            vol_l_q <= VOL_UNITY;
            vol_r_q <= VOL_UNITY;
            mute_q  <= 1'b0;
            clr_q   <= 1'b0;
        end else begin
            clr_q <= 1'b0;
            if (data_done && wr_q) begin
                case (addr_q)
                    CSR_VOL_L:    vol_l_q <= sh_next;
                    CSR_VOL_R:    vol_r_q <= sh_next;
                    CSR_CTRL:     mute_q  <= sh_next[CTRL_MUTE_BIT];
                    CSR_UNDERRUN: clr_q   <= 1'b1;
                    default:      ;
                endcase
            end
        end
    end

    assign vol_l_o        = vol_l_q;
    assign vol_r_o        = vol_r_q;
    assign mute_o         = mute_q;
    assign underrun_clr_o = clr_q;
    assign spi_miso_o     = miso_q;

    a_clr_pulse: assert property (@(posedge clk245760) disable iff (rst)
        underrun_clr_o |=> !underrun_clr_o);

endmodule

/* hdl/dac_drv.sv */
module dac_drv #(
    parameter int BCK_HALF = 4
) (
    input  logic  clk245760,
    input  logic  rst,

    dac_if.driver dac,

    output logic  bck_o,
    output logic  lrck_o,
    output logic  data_o
);

    localparam int HALF_W = (BCK_HALF > 1) ? $clog2(BCK_HALF) : 1;

    typedef enum logic [1:0] {S_POP, S_WAIT, S_SHIFT} state_t;

    state_t            state_q;
    logic [HALF_W-1:0] half_cnt_q;
    logic [4:0]        bit_cnt_q;
    logic              bck_q;
    logic              lrck_q;
    logic [31:0]       sr_q;
    logic              half_end;
    logic              bck_fall;
    logic              slot_end;
    logic              load;

    assign half_end = half_cnt_q == HALF_W'(BCK_HALF - 1);
    assign bck_fall = half_end && bck_q;
    assign slot_end = bck_fall && bit_cnt_q == 5'd31;
    assign load     = state_q == S_WAIT && (dac.ack_l || dac.ack_r);

    // bck divider, bit and slot counters
    always_ff @(posedge clk245760) begin
        if (rst) begin
            half_cnt_q <= '0;
            bck_q      <= 1'b0;
            bit_cnt_q  <= '0;
            lrck_q     <= 1'b0;
        end else begin
            if (half_end) begin
                half_cnt_q <= '0;
                bck_q      <= ~bck_q;
            end else begin
                half_cnt_q <= half_cnt_q + 1'b1;
            end
            if (bck_fall) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
            if (slot_end) begin
                lrck_q <= ~lrck_q;
            end
        end
    end

    // first slot after reset goes out without a pop, held samples are zero then
    always_ff @(posedge clk245760) begin
        if (rst) begin
            state_q   <= S_SHIFT;
            dac.pop_l <= 1'b0;
            dac.pop_r <= 1'b0;
        end else begin
            dac.pop_l <= 1'b0;
            dac.pop_r <= 1'b0;
            case (state_q)
                S_SHIFT: begin
                    if (slot_end) begin
                        // lrck about to toggle, pop the coming channel
                        dac.pop_l <= lrck_q;
                        dac.pop_r <= ~lrck_q;
                        state_q   <= S_POP;
                    end
                end
                S_POP: state_q <= S_WAIT;
                S_WAIT: begin
                    if (load) begin
                        state_q <= S_SHIFT;
                    end
                end
                default: state_q <= S_SHIFT;
            endcase
        end
    end

    // 24 sample bits then 8 zeros, msb first
    always_ff @(posedge clk245760) begin
        if (rst) begin
            sr_q <= '0;
        end else if (load) begin
            sr_q <= {dac.data, 8'h00};
        end else if (bck_fall) begin
            sr_q <= {sr_q[30:0], 1'b0};
        end
    end

    assign bck_o  = bck_q;
    assign lrck_o = lrck_q;
    assign data_o = sr_q[31];

    a_pop_ack: assert property (@(posedge clk245760) disable iff (rst)
        (dac.pop_l |=> dac.ack_l) and (dac.pop_r |=> dac.ack_r));

endmodule

/* hdl/dac_if.sv */
interface dac_if
    import hpa_pkg::*;
();

    // pop from driver, ack + data one cycle later from mixer
    logic    pop_l;
    logic    pop_r;
    logic    ack_l;
    logic    ack_r;
    sample_t data;

    modport mixer (
        input  pop_l, pop_r,
        output ack_l, ack_r, data
    );

    modport driver (
        output pop_l, pop_r,
        input  ack_l, ack_r, data
    );

endinterface

/* hdl/hpa_core.sv */
module hpa_core
    import hpa_pkg::*;
#(
    parameter int BCK_HALF = 4
) (
    input  logic    clk245760,
    input  logic    rst,

    input  sample_t sample_data_i,
    input  logic    sample_lrck_i,
    input  logic    sample_ack_i,

    input  logic    spi_sck_i,
    input  logic    spi_ss_i,
    input  logic    spi_mosi_i,
    output logic    spi_miso_o,

    output logic    dac_bck_o,
    output logic    dac_lrck_o,
    output logic    dac_data_o
);

    vol_t      vol_l;
    vol_t      vol_r;
    logic      mute;
    logic      underrun_clr;
    csr_data_t underrun_cnt;

    dac_if dac_bus ();

    // register access
    csr_spi i_csr_spi (
        .clk245760      (clk245760),
        .rst            (rst),
        .spi_sck_i      (spi_sck_i),
        .spi_ss_i       (spi_ss_i),
        .spi_mosi_i     (spi_mosi_i),
        .spi_miso_o     (spi_miso_o),
        .vol_l_o        (vol_l),
        .vol_r_o        (vol_r),
        .mute_o         (mute),
        .underrun_clr_o (underrun_clr),
        .underrun_cnt_i (underrun_cnt)
    );

    vol_mixer i_vol_mixer (
        .clk245760      (clk245760),
        .rst            (rst),
        .sample_data_i  (sample_data_i),
        .sample_lrck_i  (sample_lrck_i),
        .sample_ack_i   (sample_ack_i),
        .vol_l_i        (vol_l),
        .vol_r_i        (vol_r),
        .mute_i         (mute),
        .underrun_clr_i (underrun_clr),
        .underrun_cnt_o (underrun_cnt),
        .dac            (dac_bus.mixer)
    );

    // 48 kHz frame, 64 bck per frame
    dac_drv #(
        .BCK_HALF (BCK_HALF)
    ) i_dac_drv (
        .clk245760 (clk245760),
        .rst       (rst),
        .dac       (dac_bus.driver),
        .bck_o     (dac_bck_o),
        .lrck_o    (dac_lrck_o),
        .data_o    (dac_data_o)
    );

endmodule

/* hdl/hpa_pkg.sv */
package hpa_pkg;

    // audio sample, signed pcm
    typedef logic signed [23:0] sample_t;

    // gain, value / 32768
    typedef logic [15:0] vol_t;

    typedef logic [6:0] csr_addr_t;
    typedef logic [15:0] csr_data_t;

    // register map
    localparam csr_addr_t CSR_VOL_L    = 7'd0;
    localparam csr_addr_t CSR_VOL_R    = 7'd1;
    localparam csr_addr_t CSR_CTRL     = 7'd2;
    localparam csr_addr_t CSR_UNDERRUN = 7'd3;

    // ctrl register bits
    localparam int CTRL_MUTE_BIT = 0;

    // volume scaling
    localparam vol_t VOL_UNITY     = 16'h8000;
    localparam int   VOL_FRAC_BITS = 15;

    // clamp limits of sample_t
    localparam sample_t SAMPLE_MAX = 24'sh7f_ffff;
    localparam sample_t SAMPLE_MIN = -24'sh80_0000;

endpackage

/* hdl/vol_mixer.sv */
module vol_mixer
    import hpa_pkg::*;
(
    input  logic      clk245760,
    input  logic      rst,

    input  sample_t   sample_data_i,
    input  logic      sample_lrck_i,
    input  logic      sample_ack_i,

    input  vol_t      vol_l_i,
    input  vol_t      vol_r_i,
    input  logic      mute_i,
    input  logic      underrun_clr_i,
    output csr_data_t underrun_cnt_o,

    dac_if.mixer      dac
);

    logic signed [40:0] prod_q;
    logic               prod_vld_q;
    logic               prod_left_q;
    vol_t               vol_sel;
    logic signed [25:0] scaled;
    sample_t            clamped;
    sample_t            held_l_q;
    sample_t            held_r_q;
    logic               fresh_l_q;
    logic               fresh_r_q;
    logic               stale;
    csr_data_t          underrun_q;

    assign vol_sel = sample_lrck_i ? vol_l_i : vol_r_i;

    // stage 1, multiply with the channel gain
    always_ff @(posedge clk245760) begin
        if (mute_i) begin
            prod_q <= '0;
        end else begin
            prod_q <= sample_data_i * $signed({1'b0, vol_sel});
        end
        prod_left_q <= sample_lrck_i;
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            prod_vld_q <= 1'b0;
        end else begin
            prod_vld_q <= sample_ack_i;
        end
    end

    // stage 2, shift back and clamp
    assign scaled = 26'(prod_q >>> VOL_FRAC_BITS);

    always_comb begin
        if (scaled > 26'(SAMPLE_MAX)) begin
            clamped = SAMPLE_MAX;
        end else if (scaled < 26'(SAMPLE_MIN)) begin
            clamped = SAMPLE_MIN;
        end else begin
            clamped = scaled[23:0];
        end
    end

    // a pop with no new sample since the last one is an underrun
    assign stale = (dac.pop_l && !fresh_l_q) || (dac.pop_r && !fresh_r_q);

    always_ff @(posedge clk245760) begin
        if (rst) begin
            held_l_q   <= '0;
            held_r_q   <= '0;
            fresh_l_q  <= 1'b0;
            fresh_r_q  <= 1'b0;
            underrun_q <= '0;
        end else begin
            if (prod_vld_q && prod_left_q) begin
                held_l_q  <= clamped;
                fresh_l_q <= 1'b1;
            end else if (dac.pop_l) begin
                fresh_l_q <= 1'b0;
            end
            if (prod_vld_q && !prod_left_q) begin
                held_r_q  <= clamped;
                fresh_r_q <= 1'b1;
            end else if (dac.pop_r) begin
                fresh_r_q <= 1'b0;
            end
            if (underrun_clr_i) begin
                underrun_q <= '0;
            end else if (stale && underrun_q != 16'hffff) begin
                underrun_q <= underrun_q + 1'b1;
            end
        end
    end

    // answer every pop one cycle later
    always_ff @(posedge clk245760) begin
        if (rst) begin
            dac.ack_l <= 1'b0;
            dac.ack_r <= 1'b0;
        end else begin
            dac.ack_l <= dac.pop_l;
            dac.ack_r <= dac.pop_r;
        end
    end

    always_ff @(posedge clk245760) begin
        dac.data <= dac.pop_l ? held_l_q : held_r_q;
    end

    assign underrun_cnt_o = underrun_q;

    // pops from the driver last a single cycle
    a_pop_single: assert property (@(posedge clk245760) disable iff (rst)
        (dac.pop_l |=> !dac.pop_l) and (dac.pop_r |=> !dac.pop_r));

    a_ack_onehot: assert property (@(posedge clk245760) disable iff (rst)
        !(dac.ack_l && dac.ack_r));

endmodule

/* run.sh */
#!/bin/sh
# build the simulation from the file list, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module hpa_tb -f filelist.f -o hpa_sim || { echo "build failed"; exit 1; }

out=$(./obj_dir/hpa_sim)
echo "$out"
echo "$out" | grep -qx "TEST PASSED" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tests/hpa_tb.sv */
module hpa_tb
    import hpa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BCK_HALF   = 4;
    localparam int FRAME_CYC  = 128 * BCK_HALF;
    localparam int SPI_HALF   = 8;
    localparam int SPI_CYC    = 24 * 2 * SPI_HALF + 4 * SPI_HALF;
    localparam int NUM_FIXED  = 7;
    localparam int NUM_RANDOM = 4;
    localparam int NUM_ROWS   = NUM_FIXED + NUM_RANDOM;
    localparam int MAX_CYC    = NUM_ROWS * (3 * FRAME_CYC + 4 * SPI_CYC)
                                + 8 * FRAME_CYC + 8 * SPI_CYC;

    typedef struct packed {
        logic [23:0] smp_l;
        logic [23:0] smp_r;
        logic [15:0] vol_l;
        logic [15:0] vol_r;
        logic        mute;
        logic [23:0] exp_l;
        logic [23:0] exp_r;
    } row_t;

    logic        clk245760;
    logic        rst;
    logic [23:0] sample_data_i;
    logic        sample_lrck_i;
    logic        sample_ack_i;
    logic        spi_sck_i;
    logic        spi_ss_i;
    logic        spi_mosi_i;
    logic        spi_miso_o;
    logic        dac_bck_o;
    logic        dac_lrck_o;
    logic        dac_data_o;

    row_t        rows[$];
    string       names[$];
    int unsigned lcg_state = 11;
    int          cycle_cnt = 0;
    int          err_cnt   = 0;
    int          test_cnt  = 0;
    int          fail_cnt  = 0;
    logic        feed_stop = 1'b0;

    // last words seen on the dac pins
    logic        cap_lrck  = 1'b0;
    int          cap_idx   = 0;
    logic [23:0] cap_word  = '0;
    logic [23:0] last_l    = '0;
    logic [23:0] last_r    = '0;
    int          frame_cnt = 0;

    hpa_core #(
        .BCK_HALF (BCK_HALF)
    ) i_hpa_core (
        .clk245760     (clk245760),
        .rst           (rst),
        .sample_data_i (sample_data_i),
        .sample_lrck_i (sample_lrck_i),
        .sample_ack_i  (sample_ack_i),
        .spi_sck_i     (spi_sck_i),
        .spi_ss_i      (spi_ss_i),
        .spi_mosi_i    (spi_mosi_i),
        .spi_miso_o    (spi_miso_o),
        .dac_bck_o     (dac_bck_o),
        .dac_lrck_o    (dac_lrck_o),
        .dac_data_o    (dac_data_o)
    );

    initial begin
        clk245760 = 1'b0;
        forever begin
            #20 clk245760 = ~clk245760;
        end
    end

    always @(posedge clk245760) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == MAX_CYC) begin
            $display("timeout after %0d cycles, the run did not complete", MAX_CYC);
            $display("TEST FAILED");
            $finish;
        end
    end

    // dac latches data on rising bck, first 24 bits of a slot are the sample
    always @(posedge dac_bck_o) begin
        if (dac_lrck_o != cap_lrck) begin
            cap_lrck = dac_lrck_o;
            cap_idx  = 0;
        end
        if (cap_idx < 24) begin
            cap_word = {cap_word[22:0], dac_data_o};
            cap_idx  = cap_idx + 1;
            if (cap_idx == 24 && !cap_lrck) begin
                last_l = cap_word;
            end else if (cap_idx == 24) begin
                last_r    = cap_word;
                frame_cnt = frame_cnt + 1;
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // product with gain/32768, floor shift, clamp to 24 bits
    function automatic logic [23:0] expected_out(input logic [23:0] smp,
                                                 input logic [15:0] vol,
                                                 input logic mute);
        longint prod;
        longint shifted;
        if (mute) begin
            return 24'h000000;
        end
        prod    = longint'($signed(smp)) * longint'({1'b0, vol});
        shifted = prod >>> 15;
        if (shifted > 64'sd8388607) begin
            shifted = 64'sd8388607;
        end else if (shifted < -64'sd8388608) begin
            shifted = -64'sd8388608;
        end
        return 24'(shifted);
    endfunction

    task automatic add_row(input string name, input logic [23:0] sl, input logic [23:0] sr,
                           input logic [15:0] vl, input logic [15:0] vr, input logic m);
        row_t row;
        row.smp_l = sl;
        row.smp_r = sr;
        row.vol_l = vl;
        row.vol_r = vr;
        row.mute  = m;
        row.exp_l = expected_out(sl, vl, m);
        row.exp_r = expected_out(sr, vr, m);
        rows.push_back(row);
        names.push_back(name);
    endtask

    task automatic spi_transfer(input logic wr, input csr_addr_t addr,
                                input logic [15:0] wdata, output logic [15:0] rdata);
        logic [23:0] frame;
        int          i;
        frame = {wr, addr, wdata};
        rdata = '0;
        @(posedge clk245760);
        #2;
        spi_ss_i = 1'b0;
        for (i = 23; i >= 0; i--) begin
            // mosi set while sck low, miso read just before sck rises
            spi_mosi_i = frame[i];
            repeat (SPI_HALF) @(posedge clk245760);
            #2;
            if (i < 16) begin
                rdata = {rdata[14:0], spi_miso_o};
            end
            spi_sck_i = 1'b1;
            repeat (SPI_HALF) @(posedge clk245760);
            #2;
            spi_sck_i = 1'b0;
        end
        repeat (SPI_HALF) @(posedge clk245760);
        #2;
        spi_ss_i   = 1'b1;
        spi_mosi_i = 1'b0;
        repeat (SPI_HALF) @(posedge clk245760);
        #2;
    endtask

    task automatic write_reg(input csr_addr_t addr, input logic [15:0] data);
        logic [15:0] unused;
        spi_transfer(1'b1, addr, data, unused);
    endtask

    task automatic read_reg(input csr_addr_t addr, output logic [15:0] data);
        spi_transfer(1'b0, addr, 16'h0000, data);
    endtask

    task automatic strobe_pair(input logic [23:0] l, input logic [23:0] r);
        @(posedge clk245760);
        #2;
        sample_data_i = l;
        sample_lrck_i = 1'b1;
        sample_ack_i  = 1'b1;
        @(posedge clk245760);
        #2;
        sample_data_i = r;
        sample_lrck_i = 1'b0;
        @(posedge clk245760);
        #2;
        sample_ack_i  = 1'b0;
        sample_data_i = '0;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frame_cnt + n;
        while (frame_cnt < target) begin
            @(posedge clk245760);
        end
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [23:0] exp, input logic [23:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s %s: expected %06h, actual %06h", test, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic report_test(input string test, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok", test);
        end else begin
            fail_cnt++;
            $display("test %s: failed", test);
        end
    endtask

    initial begin
        row_t        row;
        logic [15:0] rd;
        logic [31:0] rnd;
        logic [23:0] rs_l;
        logic [23:0] rs_r;
        int          errs_before;
        int          r;
        int          k;

        sample_data_i = '0;
        sample_lrck_i = 1'b0;
        sample_ack_i  = 1'b0;
        spi_sck_i     = 1'b0;
        spi_ss_i      = 1'b1;
        spi_mosi_i    = 1'b0;
        rst           = 1'b1;
        repeat (5) @(posedge clk245760);
        #2;
        rst = 1'b0;

        add_row("unity_pos", 24'h123456, 24'h000400, VOL_UNITY, VOL_UNITY, 1'b0);
        add_row("unity_neg", 24'hdcba99, 24'hffffff, VOL_UNITY, VOL_UNITY, 1'b0);
        add_row("half_volume", 24'h200001, 24'hfffffd, 16'h4000, 16'h4000, 1'b0);
        add_row("low_volume", 24'hfffffb, 24'h300000, 16'h2000, 16'h6000, 1'b0);
        add_row("saturate", 24'h600000, 24'ha00000, 16'hffff, 16'hc000, 1'b0);
        add_row("mute_on", 24'h123456, 24'hedcbaa, VOL_UNITY, VOL_UNITY, 1'b1);
        add_row("mute_off", 24'h123456, 24'hedcbaa, VOL_UNITY, VOL_UNITY, 1'b0);
        for (k = 0; k < NUM_RANDOM; k++) begin
            rnd  = lcg_next();
            rs_l = rnd[31:8];
            rnd  = lcg_next();
            rs_r = rnd[31:8];
            rnd  = lcg_next();
            add_row($sformatf("random_%0d", k), rs_l, rs_r, rnd[31:16], rnd[15:0], 1'b0);
        end

        errs_before = err_cnt;
        read_reg(CSR_VOL_R, rd);
        check_value("reset_volume", "vol_r", {8'h00, VOL_UNITY}, {8'h00, rd});
        report_test("reset_volume", errs_before);

        for (r = 0; r < rows.size(); r++) begin
            row         = rows[r];
            errs_before = err_cnt;
            write_reg(CSR_VOL_L, row.vol_l);
            write_reg(CSR_VOL_R, row.vol_r);
            write_reg(CSR_CTRL, {15'd0, row.mute});
            read_reg(CSR_VOL_L, rd);
            check_value(names[r], "vol_l readback", {8'h00, row.vol_l}, {8'h00, rd});
            strobe_pair(row.smp_l, row.smp_r);
            wait_frames(2);
            check_value(names[r], "left", row.exp_l, last_l);
            check_value(names[r], "right", row.exp_r, last_r);
            report_test(names[r], errs_before);
        end

        // rows strobe once per two frames, so stale pops have been counted
        errs_before = err_cnt;
        read_reg(CSR_UNDERRUN, rd);
        assert (rd != 16'h0000) else begin
            $display("underrun counter still zero after frames without new samples");
            err_cnt++;
        end
        report_test("underrun_count", errs_before);

        errs_before = err_cnt;
        fork
            begin
                // one sample pair per frame at the start of each right slot
                while (!feed_stop) begin
                    @(posedge dac_lrck_o);
                    strobe_pair(24'h010203, 24'hfedcba);
                end
            end
            begin
                wait_frames(2);
                write_reg(CSR_UNDERRUN, 16'h0000);
                wait_frames(1);
                read_reg(CSR_UNDERRUN, rd);
                feed_stop = 1'b1;
            end
        join
        check_value("underrun_clear", "count", 24'h000000, {8'h00, rd});
        report_test("underrun_clear", errs_before);

        $display("%0d tests run, %0d failed, %0d errors", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
